// ==== hw/icache_data_array.sv ====
`timescale 1ns/1ns
`include "icache_defines.svh"

module icache_data_array
	import icache_pkg::*;
(
	input logic clk,
	input addr_t rd_addr,
	icache_fill_if.array fill,
	output bus_data_t [`ICACHE_WAYS-1:0] rd_data
);

	// one 64-bit word per set and beat
	localparam int depth = `ICACHE_SETS * `ICACHE_BEATS;

	bus_data_t mem_q [`ICACHE_WAYS][depth];
	logic [$clog2(depth)-1:0] wr_idx;
	logic [$clog2(depth)-1:0] rd_idx;

	// word index is {set, beat}
	assign wr_idx = {fill.set, fill.beat};
	assign rd_idx = {addr_set(rd_addr), addr_beat(rd_addr)};

	always_ff @(posedge clk) begin
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			// only the victim way takes the beat
			if (fill.valid && fill.way[w])
				mem_q[w][wr_idx] <= fill.data;
		end
	end

	// all ways read in parallel
	// selection happens one stage later
	always_ff @(posedge clk) begin
		for (int w = 0; w < `ICACHE_WAYS; w++)
			rd_data[w] <= mem_q[w][rd_idx];
	end

endmodule

// ==== hw/icache_defines.svh ====
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// cache geometry
// 4 ways x 16 sets, 64-byte lines
`define ICACHE_WAYS 4
`define ICACHE_SETS 16

// 64-bit beats per line
`define ICACHE_BEATS 8

// byte address width
`define ICACHE_ADDR_W 32

// AXI read data width
`define ICACHE_BUS_W 64

`endif

// ==== hw/icache_fetch_out.sv ====
`timescale 1ns/1ns
`include "icache_defines.svh"

module icache_fetch_out
	import icache_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic valid,
	input addr_t addr,
	input way_oh_t hit_way,
	input logic flush,
	input logic refilling,
	input bus_data_t [`ICACHE_WAYS-1:0] rd_data,
	output inst_t inst,
	output logic ready
);

	// hit way and word half of the request in flight
	way_oh_t way_q;
	logic half_q;
	bus_data_t word;
	logic take;

	assign take = valid && (hit_way != '0) && !refilling;

	always_ff @(posedge clk) begin
		if (rst || flush) begin
			ready <= 1'b0;
			way_q <= '0;
		end else begin
			ready <= take;
			way_q <= take ? hit_way : '0;
		end
	end

	// bit 2 picks the 32-bit half
	always_ff @(posedge clk)
		half_q <= addr[2];

	// one-hot way mux
	always_comb begin
		word = '0;
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			if (way_q[w])
				word = word | rd_data[w];
		end
	end

	// little endian, low address in low half
	assign inst = half_q ? word[63:32] : word[31:0];

endmodule

// ==== hw/icache_fill_if.sv ====
`timescale 1ns/1ns

// refill beats, engine to data array
// one write per cycle with valid high, no back-pressure
interface icache_fill_if
	import icache_pkg::*;
();

	logic valid;
	// target way, one-hot
	way_oh_t way;
	set_t set;
	// 64-bit word within the line
	beat_t beat;
	bus_data_t data;

	modport refill (
		output valid, way, set, beat, data
	);

	modport array (
		input valid, way, set, beat, data
	);

endinterface

// ==== hw/icache_pkg.sv ====
`include "icache_defines.svh"

package icache_pkg;

	// field widths derived from geometry
	localparam int set_w = $clog2(`ICACHE_SETS);
	localparam int beat_w = $clog2(`ICACHE_BEATS);
	localparam int off_w = beat_w + $clog2(`ICACHE_BUS_W / 8);
	localparam int tag_w = `ICACHE_ADDR_W - set_w - off_w;

	typedef logic [`ICACHE_ADDR_W-1:0] addr_t;
	typedef logic [tag_w-1:0] tag_t;
	typedef logic [set_w-1:0] set_t;
	typedef logic [beat_w-1:0] beat_t;
	typedef logic [`ICACHE_WAYS-1:0] way_oh_t;
	typedef logic [`ICACHE_BUS_W-1:0] bus_data_t;
	typedef logic [31:0] inst_t;

	// refill engine states
	typedef enum logic [1:0] {
		st_idle,
		st_request,
		st_fill
	} refill_state_e;

	// address field extraction
	function automatic tag_t addr_tag(addr_t a);
		return a[`ICACHE_ADDR_W-1 -: tag_w];
	endfunction

	function automatic set_t addr_set(addr_t a);
		return a[off_w +: set_w];
	endfunction

	function automatic beat_t addr_beat(addr_t a);
		return a[off_w-beat_w +: beat_w];
	endfunction

endpackage

// ==== hw/icache_refill.sv ====
`timescale 1ns/1ns
`include "icache_defines.svh"

module icache_refill
	import icache_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic miss,
	input way_oh_t victim,
	input addr_t addr,
	output addr_t araddr,
	output logic [7:0] arlen,
	output logic [2:0] arsize,
	output logic [1:0] arburst,
	output logic arvalid,
	input logic arready,
	input bus_data_t rdata,
	input logic rlast,
	input logic rvalid,
	output logic rready,
	output logic fill_done,
	output addr_t fill_addr,
	output logic refilling,
	icache_fill_if.refill fill
);

	refill_state_e state_q;
	refill_state_e state_d;
	// line address and way captured at AR handshake
	addr_t line_q;
	way_oh_t way_q;
	beat_t beat_q;
	logic ar_fire;
	logic beat_fire;

	// fixed INCR burst of one full line
	assign araddr = {addr[`ICACHE_ADDR_W-1:off_w], {off_w{1'b0}}};
	assign arlen = 8'(`ICACHE_BEATS - 1);
	assign arsize = 3'($clog2(`ICACHE_BUS_W / 8));
	assign arburst = 2'b01;
	assign rready = 1'b1;

	// request raised in the miss cycle, held in request state
	assign arvalid = ((state_q == st_idle) && miss) || (state_q == st_request);
	assign ar_fire = arvalid && arready;
	assign beat_fire = (state_q == st_fill) && rvalid;

	always_comb begin
		state_d = state_q;
		case (state_q)
			st_idle: if (miss) state_d = arready ? st_fill : st_request;
			st_request: if (arready) state_d = st_fill;
			st_fill: if (rvalid && rlast) state_d = st_idle;
			default: state_d = st_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= st_idle;
			beat_q <= '0;
		end else begin
			state_q <= state_d;
			if (ar_fire)
				beat_q <= '0;
			else if (beat_fire)
				beat_q <= beat_q + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (ar_fire) begin
			line_q <= araddr;
			way_q <= victim;
		end
	end

	// beat straight into the array
	assign fill.valid = beat_fire;
	assign fill.way = way_q;
	assign fill.set = addr_set(line_q);
	assign fill.beat = beat_q;
	assign fill.data = rdata;

	// last beat tells the tag store
	assign fill_done = beat_fire && rlast;
	assign fill_addr = line_q;
	assign refilling = (state_q != st_idle);

endmodule

// ==== hw/icache_tag_store.sv ====
`timescale 1ns/1ns
`include "icache_defines.svh"

module icache_tag_store
	import icache_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic valid,
	input addr_t addr,
	input logic fill_done,
	input addr_t fill_addr,
	input logic inv_valid,
	input addr_t inv_addr,
	input logic refilling,
	output way_oh_t hit_way,
	output logic miss,
	output way_oh_t victim,
	output logic lookup_hit
);

	// per-way tag rows and valid bits, indexed by set
	tag_t tag_q [`ICACHE_WAYS][`ICACHE_SETS];
	logic [`ICACHE_SETS-1:0] vld_q [`ICACHE_WAYS];
	// round-robin victim, shared by all sets
	way_oh_t victim_q;
	way_oh_t inv_hit;
	set_t req_set;
	set_t fill_set;
	set_t inv_set;
	tag_t req_tag;
	tag_t fill_tag;
	tag_t inv_tag;

	assign req_set = addr_set(addr);
	assign req_tag = addr_tag(addr);
	assign fill_set = addr_set(fill_addr);
	assign fill_tag = addr_tag(fill_addr);
	assign inv_set = addr_set(inv_addr);
	assign inv_tag = addr_tag(inv_addr);

	// parallel compare of all ways
	always_comb begin
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			hit_way[w] = vld_q[w][req_set] && (tag_q[w][req_set] == req_tag);
		end
	end

	// store snoop, also catches the line being written this cycle
	always_comb begin
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			inv_hit[w] = inv_valid && ((tag_q[w][inv_set] == inv_tag) ||
				(fill_done && victim_q[w] && (fill_set == inv_set) && (fill_tag == inv_tag)));
		end
	end

	// no lookups while a refill owns the arrays
	assign miss = valid && (hit_way == '0) && !refilling;
	assign lookup_hit = valid && (hit_way != '0) && !refilling;
	assign victim = victim_q;

	always_ff @(posedge clk) begin
		if (fill_done) begin
			for (int w = 0; w < `ICACHE_WAYS; w++) begin
				if (victim_q[w])
					tag_q[w][fill_set] <= fill_tag;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < `ICACHE_WAYS; w++)
				vld_q[w] <= '0;
			victim_q <= way_oh_t'(1);
		end else begin
			if (fill_done) begin
				for (int w = 0; w < `ICACHE_WAYS; w++) begin
					if (victim_q[w])
						vld_q[w][fill_set] <= 1'b1;
				end
				// rotate to next way
				victim_q <= {victim_q[`ICACHE_WAYS-2:0], victim_q[`ICACHE_WAYS-1]};
			end
			// later assignment, so invalidate beats a same-line fill
			for (int w = 0; w < `ICACHE_WAYS; w++) begin
				if (inv_hit[w])
					vld_q[w][inv_set] <= 1'b0;
			end
		end
	end

endmodule

// ==== hw/icache_top.sv ====
`timescale 1ns/1ns
`include "icache_defines.svh"

module icache_top
	import icache_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic valid,
	input addr_t addr,
	input logic flush,
	input logic inv_valid,
	input addr_t inv_addr,
	output inst_t inst,
	output logic ready,
	output logic lookup_hit,
	output addr_t araddr,
	output logic [7:0] arlen,
	output logic [2:0] arsize,
	output logic [1:0] arburst,
	output logic arvalid,
	input logic arready,
	input bus_data_t rdata,
	input logic rlast,
	input logic rvalid,
	output logic rready
);

	way_oh_t hit_way;
	way_oh_t victim;
	logic miss;
	logic fill_done;
	addr_t fill_addr;
	logic refilling;
	bus_data_t [`ICACHE_WAYS-1:0] rd_data;

	// refill beats to the data array
	icache_fill_if fill_bus ();

	icache_tag_store tag_store_i (
		.clk(clk), .rst(rst), .valid(valid), .addr(addr),
		.fill_done(fill_done), .fill_addr(fill_addr),
		.inv_valid(inv_valid), .inv_addr(inv_addr), .refilling(refilling),
		.hit_way(hit_way), .miss(miss), .victim(victim), .lookup_hit(lookup_hit)
	);

	icache_refill refill_i (
		.clk(clk), .rst(rst), .miss(miss), .victim(victim), .addr(addr),
		.araddr(araddr), .arlen(arlen), .arsize(arsize), .arburst(arburst),
		.arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rlast(rlast), .rvalid(rvalid), .rready(rready),
		.fill_done(fill_done), .fill_addr(fill_addr), .refilling(refilling),
		.fill(fill_bus.refill)
	);

	// read address is the live request
	icache_data_array data_array_i (
		.clk(clk), .rd_addr(addr), .fill(fill_bus.array), .rd_data(rd_data)
	);

	icache_fetch_out fetch_out_i (
		.clk(clk), .rst(rst), .valid(valid), .addr(addr), .hit_way(hit_way),
		.flush(flush), .refilling(refilling), .rd_data(rd_data),
		.inst(inst), .ready(ready)
	);

endmodule

// ==== icache.f ====
+incdir+hw
hw/icache_pkg.sv
hw/icache_fill_if.sv
hw/icache_tag_store.sv
hw/icache_refill.sv
hw/icache_data_array.sv
hw/icache_fetch_out.sv
hw/icache_top.sv
sim/tb_clock_gen.sv
sim/axi_mem_model.sv
sim/icache_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the instruction cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f icache.f --top-module icache_tb -Mdir obj_dir
./obj_dir/Vicache_tb > sim.log
cat sim.log

if grep -q "^Testbench passed$" sim.log; then
	exit 0
fi
exit 1

// ==== sim/axi_mem_model.sv ====
`timescale 1ns/1ns

// AXI read responder
// word at address A reads back as {A, ~A}
module axi_mem_model
	import icache_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic arvalid,
	input addr_t araddr,
	input logic [7:0] arlen,
	input logic [2:0] arsize,
	input logic [1:0] arburst,
	output logic arready,
	output bus_data_t rdata,
	output logic rlast,
	output logic rvalid,
	input logic rready,
	output int ar_count,
	output addr_t last_araddr,
	output logic [7:0] last_arlen,
	output logic [2:0] last_arsize,
	output logic [1:0] last_arburst
);

	integer seed;
	int delay;
	int len;
	addr_t base;

	function automatic bus_data_t mem_word(addr_t a);
		return {a, ~a};
	endfunction

	initial begin
		seed = 24197;
		arready = 1'b0;
		rvalid = 1'b0;
		rlast = 1'b0;
		rdata = '0;
		ar_count = 0;
		last_araddr = '0;
		last_arlen = '0;
		last_arsize = '0;
		last_arburst = '0;
		forever begin
			// look for a request mid-cycle, where it is stable
			@(negedge clk);
			if (!rst && arvalid) begin
				base = araddr;
				len = int'(arlen);
				last_araddr = araddr;
				last_arlen = arlen;
				last_arsize = arsize;
				last_arburst = arburst;
				// random address stall
				delay = $unsigned($random(seed)) % 4;
				repeat (delay) @(posedge clk);
				@(posedge clk);
				#1;
				arready = 1'b1;
				// request is held, so the handshake lands on this edge
				@(posedge clk);
				#1;
				arready = 1'b0;
				ar_count++;
				// INCR burst, one 64-bit word per beat
				for (int i = 0; i <= len; i++) begin
					rvalid = 1'b1;
					rdata = mem_word(base + addr_t'(i) * 8);
					rlast = (i == len);
					@(negedge clk);
					while (!rready)
						@(negedge clk);
					@(posedge clk);
					#1;
				end
				rvalid = 1'b0;
				rlast = 1'b0;
			end
		end
	end

endmodule

// ==== sim/icache_tb.sv ====
`timescale 1ns/1ns

module icache_tb
	import icache_pkg::*;
();

	// worst case about 40 accesses of up to 40 cycles each
	localparam int max_accesses = 40;
	localparam int max_access_cycles = 40;
	// three times that plus reset and idle margin
	localparam int max_cycles = 3 * max_accesses * max_access_cycles + 200;

	logic clk;
	logic rst;
	logic valid;
	addr_t addr;
	logic flush;
	logic inv_valid;
	addr_t inv_addr;
	inst_t inst;
	logic ready;
	logic lookup_hit;
	addr_t araddr;
	logic [7:0] arlen;
	logic [2:0] arsize;
	logic [1:0] arburst;
	logic arvalid;
	logic arready;
	bus_data_t rdata;
	logic rlast;
	logic rvalid;
	logic rready;
	int ar_count;
	addr_t last_araddr;
	logic [7:0] last_arlen;
	logic [2:0] last_arsize;
	logic [1:0] last_arburst;

	string test_name;
	int checks = 0;
	int errors = 0;
	int cycles = 0;

	tb_clock_gen clock_gen_i (
		.clk(clk), .rst(rst)
	);

	icache_top icache_top_i (
		.clk(clk), .rst(rst), .valid(valid), .addr(addr), .flush(flush),
		.inv_valid(inv_valid), .inv_addr(inv_addr),
		.inst(inst), .ready(ready), .lookup_hit(lookup_hit),
		.araddr(araddr), .arlen(arlen), .arsize(arsize), .arburst(arburst),
		.arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rlast(rlast), .rvalid(rvalid), .rready(rready)
	);

	axi_mem_model mem_i (
		.clk(clk), .rst(rst), .arvalid(arvalid), .araddr(araddr), .arlen(arlen),
		.arsize(arsize), .arburst(arburst), .arready(arready),
		.rdata(rdata), .rlast(rlast), .rvalid(rvalid), .rready(rready),
		.ar_count(ar_count), .last_araddr(last_araddr), .last_arlen(last_arlen),
		.last_arsize(last_arsize), .last_arburst(last_arburst)
	);

	// instruction the memory data rule gives for a byte address
	function automatic inst_t expected_inst(addr_t a);
		addr_t word_addr;
		word_addr = {a[31:3], 3'b000};
		// upper half is the word address and lower half its inverse
		return a[2] ? word_addr : ~word_addr;
	endfunction

	task automatic compare_inst(input string what, input inst_t exp, input inst_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("** Error %s, %s: expected %h, actual %h", test_name, what, exp, act);
		end
	endtask

	task automatic compare_addr(input string what, input addr_t exp, input addr_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("** Error %s, %s: expected %h, actual %h", test_name, what, exp, act);
		end
	endtask

	// AR control fields zero-extended to 8 bits
	task automatic compare_field(input string what, input logic [7:0] exp,
			input logic [7:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("** Error %s, %s: expected %0d, actual %0d", test_name, what, exp, act);
		end
	endtask

	task automatic compare_flag(input string what, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("** Error %s, %s: expected %b, actual %b", test_name, what, exp, act);
		end
	endtask

	task automatic compare_count(input string what, input int exp, input int act);
		checks++;
		if (act != exp) begin
			errors++;
			$display("** Error %s, %s: expected %0d, actual %0d", test_name, what, exp, act);
		end
	endtask

	// holds the request from mid-cycle until the ready cycle and then drops it
	task automatic await_ready(output inst_t got);
		@(posedge clk);
		#1;
		while (!ready) begin
			@(posedge clk);
			#1;
		end
		got = inst;
		valid = 1'b0;
	endtask

	// starts 1 ns after a rising edge and returns at the same point of the ready cycle
	task automatic fetch(input addr_t a, output inst_t got, output logic first_hit);
		valid = 1'b1;
		addr = a;
		// lookup result is settled by mid-cycle
		@(negedge clk);
		first_hit = lookup_hit;
		await_ready(got);
	endtask

	task automatic test_miss_then_hit();
		inst_t got;
		logic hit;
		int ars;
		test_name = "miss_then_hit";
		ars = ar_count;
		fetch(32'h0000_1040, got, hit);
		compare_flag("first lookup_hit", 1'b0, hit);
		compare_inst("miss inst", expected_inst(32'h0000_1040), got);
		compare_count("AR count after miss", ars + 1, ar_count);
		// same address again
		fetch(32'h0000_1040, got, hit);
		compare_flag("repeat lookup_hit", 1'b1, hit);
		compare_inst("hit inst", expected_inst(32'h0000_1040), got);
		compare_count("AR count after hit", ars + 1, ar_count);
	endtask

	task automatic test_word_select();
		inst_t got;
		logic hit;
		int ars;
		addr_t a;
		test_name = "word_select";
		ars = ar_count;
		// every 32-bit word of one line
		for (int i = 0; i < 16; i++) begin
			a = 32'h0000_2080 | addr_t'(i << 2);
			fetch(a, got, hit);
			compare_inst("word inst", expected_inst(a), got);
		end
		compare_count("AR count for line", ars + 1, ar_count);
	endtask

	task automatic test_burst_request();
		inst_t got;
		int ars;
		test_name = "burst_request";
		ars = ar_count;
		// unaligned fetch whose burst must start at the line base
		valid = 1'b1;
		addr = 32'h0000_30D4;
		@(negedge clk);
		// AR goes out in the miss cycle itself
		compare_flag("miss cycle arvalid", 1'b1, arvalid);
		compare_flag("miss cycle rready", 1'b1, rready);
		await_ready(got);
		compare_inst("miss inst", expected_inst(32'h0000_30D4), got);
		compare_count("AR count for burst", ars + 1, ar_count);
		compare_addr("araddr", 32'h0000_30C0, last_araddr);
		compare_field("arlen", 8'd7, last_arlen);
		compare_field("arsize", 8'd3, {5'b0, last_arsize});
		compare_field("arburst", 8'd1, {6'b0, last_arburst});
	endtask

	task automatic test_round_robin();
		inst_t got;
		logic hit;
		int ars;
		addr_t line [5];
		test_name = "round_robin";
		// five tags all in set 5
		for (int k = 0; k < 5; k++)
			line[k] = 32'h0001_0140 + addr_t'(k) * 32'h400;
		for (int k = 0; k < 5; k++) begin
			fetch(line[k], got, hit);
			compare_flag("fill lookup_hit", 1'b0, hit);
			compare_inst("fill inst", expected_inst(line[k]), got);
		end
		// five refills walk five pointer steps
		// fifth lands on the first line's way
		ars = ar_count;
		fetch(line[0], got, hit);
		compare_flag("evicted lookup_hit", 1'b0, hit);
		compare_inst("evicted inst", expected_inst(line[0]), got);
		// refetch took the second line's way so lines 3 to 5 stay
		for (int k = 2; k < 5; k++) begin
			fetch(line[k], got, hit);
			compare_flag("kept lookup_hit", 1'b1, hit);
			compare_inst("kept inst", expected_inst(line[k]), got);
		end
		compare_count("AR count after eviction", ars + 1, ar_count);
	endtask

	task automatic test_invalidate();
		inst_t got;
		logic hit;
		int ars;
		test_name = "invalidate";
		fetch(32'h0000_1040, got, hit);
		compare_flag("cached lookup_hit", 1'b1, hit);
		// store to another word of the same line
		inv_valid = 1'b1;
		inv_addr = 32'h0000_1058;
		@(posedge clk);
		#1;
		inv_valid = 1'b0;
		ars = ar_count;
		fetch(32'h0000_1040, got, hit);
		compare_flag("invalidated lookup_hit", 1'b0, hit);
		compare_inst("refetch inst", expected_inst(32'h0000_1040), got);
		compare_count("AR count after invalidate", ars + 1, ar_count);
	endtask

	task automatic test_flush();
		inst_t got;
		logic hit;
		test_name = "flush";
		// hit request with flush in the same cycle
		valid = 1'b1;
		addr = 32'h0000_208C;
		flush = 1'b1;
		@(negedge clk);
		compare_flag("flushed lookup_hit", 1'b1, lookup_hit);
		@(posedge clk);
		#1;
		valid = 1'b0;
		flush = 1'b0;
		compare_flag("ready after flush", 1'b0, ready);
		@(posedge clk);
		#1;
		compare_flag("ready one cycle later", 1'b0, ready);
		fetch(32'h0000_208C, got, hit);
		compare_flag("later lookup_hit", 1'b1, hit);
		compare_inst("later inst", expected_inst(32'h0000_208C), got);
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles) begin
			$display("timeout: run still going after %0d cycles", cycles);
			$display("%0d checks, %0d errors", checks, errors);
			$display("Testbench failed");
			$finish;
		end
	end

	initial begin
		valid = 1'b0;
		addr = '0;
		flush = 1'b0;
		inv_valid = 1'b0;
		inv_addr = '0;
		test_name = "reset";
		wait (!rst);
		@(posedge clk);
		#1;
		test_miss_then_hit();
		test_word_select();
		test_burst_request();
		test_round_robin();
		test_invalidate();
		test_flush();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/1ns

// 10 ns clock, reset held for the first 10 cycles
module tb_clock_gen (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// release just after the tenth rising edge
	initial begin
		rst = 1'b1;
		repeat (10) @(posedge clk);
		#1;
		rst = 1'b0;
	end

endmodule
